//--- pinmux.f
+incdir+logic
logic/pinmux_pkg.sv
logic/pinmux_regs.sv
logic/tick_gen.sv
logic/pwm_channel.sv
logic/pad_mux.sv
logic/pinmux.sv
tests/pinmux_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the pinmux testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module pinmux_tb -f pinmux.f -o pinmux_sim \
  && ./obj_dir/pinmux_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q '>>> FAIL' sim.log && { echo "simulation failed"; exit 1; } \
  || { grep -q '>>> PASS' sim.log && echo "simulation passed"; } \
  || { echo "no result in log"; exit 1; }

//--- tests/pinmux_tb.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux_tb;

  localparam int CLK_NS    = 4;
  // ms tick period in cycles with pulse_us = 1
  localparam int MS_CYC    = 2 * `PINMUX_US_PER_MS;
  localparam int BUS_LIMIT = 8;
  localparam int RUN_LIMIT = 5 * MS_CYC;
  // Tick test, three periods plus sync per PWM channel, disable window, margin
  localparam int WD_MS     = 3 + (3 * 5 + 1) + (3 * 4 + 1) + 3 + 10;
  localparam int NUM_STEPS = 35;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_PAD} op_e;

  // One table row, exp holds {oen, out} for pad checks
  typedef struct packed {
    op_e                   op;
    pinmux_pkg::reg_addr_t addr;
    pinmux_pkg::reg_data_t data;
    pinmux_pkg::reg_be_t   be;
    pinmux_pkg::reg_data_t exp;
    pinmux_pkg::pad_vec_t  pad_in;
  } step_t;

  logic                  mclk;
  logic                  reset_i;
  pinmux_pkg::reg_req_t  reg_req;
  pinmux_pkg::reg_data_t reg_rdata;
  logic                  reg_ack;
  pinmux_pkg::pad_vec_t  pad_in;
  pinmux_pkg::pad_vec_t  pad_out;
  pinmux_pkg::pad_vec_t  pad_oen;
  logic                  pulse1m;

  step_t                 tbl [NUM_STEPS];
  logic [31:0]           lfsr_q = 32'h14a955d2;
  // Model of the GPIO setup and which pads PWM owns
  pinmux_pkg::pad_vec_t  gpio_dir;
  pinmux_pkg::pad_vec_t  gpio_out;
  pinmux_pkg::pad_vec_t  pwm_mask;
  int                    errors;
  int                    checks;
  int                    tests;

  pinmux DUT (
    .mclk        (mclk),
    .reset_i     (reset_i),
    .reg_req_i   (reg_req),
    .reg_rdata_o (reg_rdata),
    .reg_ack_o   (reg_ack),
    .pad_in_i    (pad_in),
    .pad_out_o   (pad_out),
    .pad_oen_o   (pad_oen),
    .pulse1m_o   (pulse1m)
  );

  initial begin
    mclk = 1'b0;
    forever #(CLK_NS / 2) mclk = ~mclk;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic pinmux_pkg::pad_vec_t draw_pads();
    pinmux_pkg::pad_vec_t v;
    for (int b = 0; b < `PINMUX_PAD_COUNT; b++) begin
      v[b] = lfsr_bit();
    end
    return v;
  endfunction

  function automatic pinmux_pkg::reg_addr_t pwm_addr(input int ch);
    return pinmux_pkg::reg_addr_t'(`PINMUX_REG_PWM_BASE + `PINMUX_REG_PWM_STRIDE * ch);
  endfunction

  function automatic step_t entry(input op_e op, input pinmux_pkg::reg_addr_t addr,
                                  input pinmux_pkg::reg_data_t data,
                                  input pinmux_pkg::reg_be_t be,
                                  input pinmux_pkg::reg_data_t exp,
                                  input pinmux_pkg::pad_vec_t pins);
    return '{op, addr, data, be, exp, pins};
  endfunction

  // Inputs change and outputs are sampled 1 ns after the edge
  task automatic next_cycle();
    @(posedge mclk);
    #1;
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic report(input string name, input int err_start);
    tests++;
    if (errors == err_start) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      $display("test %0d %s: %0d errors", tests, name, errors - err_start);
    end
  endtask

  // ----------------------------------------------------------------------
  // Register bus
  // ----------------------------------------------------------------------
  task automatic bus_access(input logic wr, input pinmux_pkg::reg_addr_t addr,
                            input pinmux_pkg::reg_data_t data,
                            input pinmux_pkg::reg_be_t be,
                            output pinmux_pkg::reg_data_t rdata);
    int cyc;
    cyc           = 0;
    reg_req.cs    = 1'b1;
    reg_req.wr    = wr;
    reg_req.addr  = addr;
    reg_req.wdata = data;
    reg_req.be    = be;
    do begin
      next_cycle();
      cyc++;
    end while (!reg_ack && cyc < BUS_LIMIT);
    rdata = reg_rdata;
    assert (reg_ack) else begin
      $display("register bus gave no ack within %0d cycles, address %02h", BUS_LIMIT, addr);
      errors++;
    end
    // cs low for a cycle between accesses
    reg_req = '0;
    next_cycle();
  endtask

  task automatic bus_write(input pinmux_pkg::reg_addr_t addr, input pinmux_pkg::reg_data_t data,
                           input pinmux_pkg::reg_be_t be);
    pinmux_pkg::reg_data_t unused;
    bus_access(1'b1, addr, data, be, unused);
  endtask

  task automatic bus_read(input pinmux_pkg::reg_addr_t addr,
                          output pinmux_pkg::reg_data_t rdata);
    bus_access(1'b0, addr, '0, 4'hF, rdata);
  endtask

  // ----------------------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------------------
  task automatic load_table();
    // Reset values of every register and the pads
    tbl[0] = entry(OP_PAD, 8'h00, '0, '0, 32'hFFFF_0000, '0);
    tbl[1] = entry(OP_RD, `PINMUX_REG_GPIO_DIR, '0, '0, '0, '0);
    tbl[2] = entry(OP_RD, `PINMUX_REG_GPIO_OUT, '0, '0, '0, '0);
    tbl[3] = entry(OP_RD, `PINMUX_REG_GPIO_IN, '0, '0, '0, '0);
    tbl[4] = entry(OP_RD, `PINMUX_REG_MULTI_FUNC, '0, '0, '0, '0);
    tbl[5] = entry(OP_RD, `PINMUX_REG_PULSE_US, '0, '0, '0, '0);
    for (int i = 0; i < `PINMUX_PWM_COUNT; i++) begin
      tbl[6 + i] = entry(OP_RD, pwm_addr(i), '0, '0, '0, '0);
    end
    // Partial byte writes merge into the stored value
    tbl[12] = entry(OP_WR, `PINMUX_REG_GPIO_DIR, 32'h1234_ABCD, 4'b0001, '0, '0);
    tbl[13] = entry(OP_RD, `PINMUX_REG_GPIO_DIR, '0, '0, 32'h0000_00CD, '0);
    tbl[14] = entry(OP_WR, `PINMUX_REG_GPIO_DIR, 32'hFFFF_5600, 4'b0010, '0, '0);
    tbl[15] = entry(OP_RD, `PINMUX_REG_GPIO_DIR, '0, '0, 32'h0000_56CD, '0);
    tbl[16] = entry(OP_PAD, 8'h00, '0, '0, 32'hA932_0000, '0);
    tbl[17] = entry(OP_WR, `PINMUX_REG_GPIO_OUT, 32'hFFFF_FFFF, 4'b0011, '0, '0);
    tbl[18] = entry(OP_PAD, 8'h00, '0, '0, 32'hA932_56CD, '0);
    tbl[19] = entry(OP_WR, pwm_addr(2), 32'hAABB_CCDD, 4'b1010, '0, '0);
    tbl[20] = entry(OP_RD, pwm_addr(2), '0, '0, 32'hAA00_CC00, '0);
    tbl[21] = entry(OP_WR, pwm_addr(2), 32'h1122_3344, 4'b0101, '0, '0);
    tbl[22] = entry(OP_RD, pwm_addr(2), '0, '0, 32'hAA22_CC44, '0);
    // Holes in the map
    tbl[23] = entry(OP_WR, 8'h14, 32'hDEAD_BEEF, 4'b1111, '0, '0);
    tbl[24] = entry(OP_RD, 8'h14, '0, '0, '0, '0);
    tbl[25] = entry(OP_RD, 8'h40, '0, '0, '0, '0);
    // GPIO_IN ignores writes
    tbl[26] = entry(OP_WR, `PINMUX_REG_GPIO_IN, 32'hFFFF_FFFF, 4'b1111, '0, 16'h0F0F);
    tbl[27] = entry(OP_RD, `PINMUX_REG_GPIO_IN, '0, '0, 32'h0000_0F0F, 16'h0F0F);
    tbl[28] = entry(OP_WR, `PINMUX_REG_PULSE_US, 32'hFFFF_FFFF, 4'b1111, '0, '0);
    tbl[29] = entry(OP_RD, `PINMUX_REG_PULSE_US, '0, '0, 32'h0000_03FF, '0);
    // Back to idle
    tbl[30] = entry(OP_WR, `PINMUX_REG_GPIO_DIR, '0, 4'b1111, '0, '0);
    tbl[31] = entry(OP_WR, `PINMUX_REG_GPIO_OUT, '0, 4'b1111, '0, '0);
    tbl[32] = entry(OP_WR, pwm_addr(2), '0, 4'b1111, '0, '0);
    tbl[33] = entry(OP_WR, `PINMUX_REG_PULSE_US, '0, 4'b1111, '0, '0);
    tbl[34] = entry(OP_PAD, 8'h00, '0, '0, 32'hFFFF_0000, '0);
  endtask

  task automatic apply_table(input int first, input int last);
    pinmux_pkg::reg_data_t rd;
    for (int i = first; i <= last; i++) begin
      // Pad input one cycle early so the snapshot has it
      pad_in = tbl[i].pad_in;
      next_cycle();
      case (tbl[i].op)
        OP_WR: bus_write(tbl[i].addr, tbl[i].data, tbl[i].be);
        OP_RD: begin
          bus_read(tbl[i].addr, rd);
          check($sformatf("reg_rdata_o[%02h]", tbl[i].addr), tbl[i].exp, rd);
        end
        OP_PAD: check("{pad_oen_o,pad_out_o}", tbl[i].exp, {pad_oen, pad_out});
        default: ;
      endcase
    end
  endtask

  // ----------------------------------------------------------------------
  // GPIO, tick and PWM checks
  // ----------------------------------------------------------------------
  // Non PWM pads follow dir and out, PWM pads drive with oen 0
  task automatic check_gpio_pads(input string tag);
    check({tag, " pad_out_o"}, {16'h0, gpio_out & gpio_dir & ~pwm_mask}, {16'h0, pad_out & ~pwm_mask});
    check({tag, " pad_oen_o"}, {16'h0, ~gpio_dir & ~pwm_mask}, {16'h0, pad_oen});
  endtask

  task automatic gpio_test();
    pinmux_pkg::pad_vec_t  pins;
    pinmux_pkg::reg_data_t rd;
    pwm_mask = '0;
    repeat (8) begin
      gpio_dir = draw_pads();
      gpio_out = draw_pads();
      pins     = draw_pads();
      bus_write(`PINMUX_REG_GPIO_DIR, {16'h0, gpio_dir}, 4'hF);
      bus_write(`PINMUX_REG_GPIO_OUT, {16'h0, gpio_out}, 4'hF);
      pad_in = pins;
      next_cycle();
      bus_read(`PINMUX_REG_GPIO_IN, rd);
      check("reg_rdata_o[GPIO_IN]", {16'h0, pins}, rd);
      check_gpio_pads("gpio");
    end
  endtask

  task automatic wait_pulse(output int cyc);
    cyc = 0;
    do begin
      next_cycle();
      cyc++;
    end while (!pulse1m && cyc < RUN_LIMIT);
    assert (pulse1m) else begin
      $display("no pulse1m_o seen within %0d cycles", RUN_LIMIT);
      errors++;
    end
  endtask

  task automatic tick_test();
    int cyc;
    bus_write(`PINMUX_REG_PULSE_US, 32'd1, 4'hF);
    // First interval may be partial
    wait_pulse(cyc);
    repeat (2) begin
      wait_pulse(cyc);
      check("pulse1m_o period", 32'(MS_CYC), 32'(cyc));
    end
  endtask

  // Count ms ticks while the pad holds one level
  task automatic count_run(input int ch, input logic level, output int ticks);
    int cyc;
    ticks = 0;
    cyc   = 0;
    while (pad_out[ch] === level && cyc < RUN_LIMIT) begin
      if (pulse1m) begin
        ticks++;
      end
      next_cycle();
      cyc++;
    end
    assert (cyc < RUN_LIMIT) else begin
      $display("pad %0d stuck at %0b for %0d cycles", ch, level, RUN_LIMIT);
      errors++;
    end
  endtask

  task automatic measure_pwm(input int ch, input int high, input int low);
    int n;
    // Sync to a rising pad
    count_run(ch, 1'b1, n);
    count_run(ch, 1'b0, n);
    repeat (2) begin
      check_gpio_pads($sformatf("pwm %0d", ch));
      count_run(ch, 1'b1, n);
      check($sformatf("pad_out_o[%0d] high ticks", ch), 32'(high), 32'(n));
      count_run(ch, 1'b0, n);
      check($sformatf("pad_out_o[%0d] low ticks", ch), 32'(low), 32'(n));
    end
  endtask

  task automatic pwm_test();
    // Low phase in the upper half
    bus_write(pwm_addr(0), 32'h0003_0002, 4'hF);
    bus_write(pwm_addr(3), 32'h0001_0003, 4'hF);
    bus_write(`PINMUX_REG_MULTI_FUNC, 32'h0000_0009, 4'hF);
    pwm_mask = 16'h0009;
    measure_pwm(0, 2, 3);
    measure_pwm(3, 3, 1);
  endtask

  task automatic disable_test();
    logic wfm_seen;
    logic pad_bad;
    wfm_seen = 1'b0;
    pad_bad  = 1'b0;
    bus_write(`PINMUX_REG_MULTI_FUNC, 32'h0000_0008, 4'hF);
    pwm_mask = 16'h0008;
    repeat (3 * MS_CYC) begin
      next_cycle();
      if (DUT.pwm_wfm[0] !== 1'b0) begin
        wfm_seen = 1'b1;
      end
      if (pad_out[0] !== (gpio_out[0] & gpio_dir[0]) || pad_oen[0] !== ~gpio_dir[0]) begin
        pad_bad = 1'b1;
      end
    end
    check("pwm_wfm[0] high after disable", '0, {31'h0, wfm_seen});
    check("pad 0 off GPIO rules after disable", '0, {31'h0, pad_bad});
    bus_write(`PINMUX_REG_MULTI_FUNC, 32'h0, 4'hF);
    pwm_mask = '0;
    check_gpio_pads("all pwm off");
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    int err_start;
    reset_i  = 1'b1;
    reg_req  = '0;
    pad_in   = '0;
    gpio_dir = '0;
    gpio_out = '0;
    pwm_mask = '0;
    errors   = 0;
    checks   = 0;
    tests    = 0;
    load_table();
    repeat (5) @(posedge mclk);
    #1;
    reset_i = 1'b0;
    next_cycle();

    err_start = errors;
    apply_table(0, 11);
    report("reset values", err_start);
    err_start = errors;
    apply_table(12, NUM_STEPS - 1);
    report("register access", err_start);
    err_start = errors;
    gpio_test();
    report("gpio random", err_start);
    err_start = errors;
    tick_test();
    report("ms tick period", err_start);
    err_start = errors;
    pwm_test();
    report("pwm override", err_start);
    err_start = errors;
    disable_test();
    report("pwm disable", err_start);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WD_MS * MS_CYC) @(posedge mclk);
    $display("watchdog expired after %0d cycles, run did not finish", WD_MS * MS_CYC);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- logic/pinmux.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux (
  input  logic                  mclk,
  input  logic                  reset_i,
  // Register bus
  input  pinmux_pkg::reg_req_t  reg_req_i,
  output pinmux_pkg::reg_data_t reg_rdata_o,
  output logic                  reg_ack_o,
  // Pads
  input  pinmux_pkg::pad_vec_t  pad_in_i,
  output pinmux_pkg::pad_vec_t  pad_out_o,
  output pinmux_pkg::pad_vec_t  pad_oen_o,
  // Millisecond tick
  output logic                  pulse1m_o
);

  pinmux_pkg::gpio_cfg_t        gpio_cfg;
  pinmux_pkg::pwm_cfg_t         pwm_cfg [`PINMUX_PWM_COUNT];
  pinmux_pkg::us_cnt_t          pulse_us;
  logic                         ms_tick;
  logic [`PINMUX_PWM_COUNT-1:0] pwm_enb;
  logic [`PINMUX_PWM_COUNT-1:0] pwm_wfm;

  // ----------------------------------------------------------------------
  // Config and timebase
  // ----------------------------------------------------------------------
  pinmux_regs u_regs (
    .mclk        (mclk),
    .reset_i     (reset_i),
    .reg_req_i   (reg_req_i),
    .reg_rdata_o (reg_rdata_o),
    .reg_ack_o   (reg_ack_o),
    .pad_in_i    (pad_in_i),
    .gpio_cfg_o  (gpio_cfg),
    .pwm_cfg_o   (pwm_cfg),
    .pulse_us_o  (pulse_us)
  );

  tick_gen u_tick_gen (
    .mclk       (mclk),
    .reset_i    (reset_i),
    .pulse_us_i (pulse_us),
    .ms_tick_o  (ms_tick)
  );

  assign pulse1m_o = ms_tick;

  // ----------------------------------------------------------------------
  // PWM channels
  // ----------------------------------------------------------------------
  for (genvar g = 0; g < `PINMUX_PWM_COUNT; g++) begin : g_pwm
    pwm_channel u_pwm (
      .mclk       (mclk),
      .reset_i    (reset_i),
      .ms_tick_i  (ms_tick),
      .cfg_i      (pwm_cfg[g]),
      .waveform_o (pwm_wfm[g])
    );
    // Enable also steers the pad
    assign pwm_enb[g] = pwm_cfg[g].enb;
  end

  // Pad selection
  pad_mux u_pad_mux (
    .gpio_cfg_i (gpio_cfg),
    .pwm_enb_i  (pwm_enb),
    .pwm_wfm_i  (pwm_wfm),
    .pad_out_o  (pad_out_o),
    .pad_oen_o  (pad_oen_o)
  );

endmodule

//--- logic/pad_mux.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pad_mux (
  input  pinmux_pkg::gpio_cfg_t        gpio_cfg_i,
  input  logic [`PINMUX_PWM_COUNT-1:0] pwm_enb_i,
  input  logic [`PINMUX_PWM_COUNT-1:0] pwm_wfm_i,
  output pinmux_pkg::pad_vec_t         pad_out_o,
  output pinmux_pkg::pad_vec_t         pad_oen_o
);

  // ----------------------------------------------------------------------
  // Pad steering
  // ----------------------------------------------------------------------
  // oen is active low, 1 leaves the pad as input
  always_comb begin
    // GPIO rules on every pad
    for (int p = 0; p < `PINMUX_PAD_COUNT; p++) begin
      if (gpio_cfg_i.dir[p]) begin
        pad_out_o[p] = gpio_cfg_i.out[p];
        pad_oen_o[p] = 1'b0;
      end else begin
        // Input pad, drive nothing
        pad_out_o[p] = 1'b0;
        pad_oen_o[p] = 1'b1;
      end
    end

    // PWM channel n owns pad n when enabled
    for (int c = 0; c < `PINMUX_PWM_COUNT; c++) begin
      if (pwm_enb_i[c]) begin
        pad_out_o[c] = pwm_wfm_i[c];
        pad_oen_o[c] = 1'b0;
      end
    end
  end

endmodule

//--- logic/pwm_channel.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pwm_channel (
  input  logic                 mclk,
  input  logic                 reset_i,
  input  logic                 ms_tick_i,
  input  pinmux_pkg::pwm_cfg_t cfg_i,
  output logic                 waveform_o
);

  pinmux_pkg::pwm_phase_e state_q;
  pinmux_pkg::pwm_phase_e state_nxt;
  pinmux_pkg::pwm_time_t  cnt_q;
  pinmux_pkg::pwm_time_t  cnt_nxt;
  pinmux_pkg::pwm_time_t  cnt_inc;
  logic                   wfm_q;

  // ----------------------------------------------------------------------
  // Phase FSM, advances on ms ticks only
  // ----------------------------------------------------------------------
  always_comb begin
    state_nxt = state_q;
    cnt_nxt   = cnt_q;
    cnt_inc   = cnt_q + `PINMUX_PWM_WIDTH'(1);
    if (!cfg_i.enb) begin
      // Disable wins over any tick
      state_nxt = pinmux_pkg::PWM_IDLE;
      cnt_nxt   = '0;
    end else if (ms_tick_i) begin
      case (state_q)
        pinmux_pkg::PWM_IDLE: begin
          state_nxt = pinmux_pkg::PWM_HIGH;
          cnt_nxt   = '0;
        end
        pinmux_pkg::PWM_HIGH: begin
          if (cnt_inc >= cfg_i.high) begin
            state_nxt = pinmux_pkg::PWM_LOW;
            cnt_nxt   = '0;
          end else begin
            cnt_nxt = cnt_inc;
          end
        end
        pinmux_pkg::PWM_LOW: begin
          if (cnt_inc >= cfg_i.low) begin
            state_nxt = pinmux_pkg::PWM_HIGH;
            cnt_nxt   = '0;
          end else begin
            cnt_nxt = cnt_inc;
          end
        end
        default: state_nxt = pinmux_pkg::PWM_IDLE;
      endcase
    end
  end

  // Waveform flop tracks the HIGH phase
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      state_q <= pinmux_pkg::PWM_IDLE;
      cnt_q   <= '0;
      wfm_q   <= 1'b0;
    end else begin
      state_q <= state_nxt;
      cnt_q   <= cnt_nxt;
      wfm_q   <= (state_nxt == pinmux_pkg::PWM_HIGH);
    end
  end

  assign waveform_o = wfm_q;

  // Pad must fall back to GPIO cleanly after disable
  a_wfm_off: assert property (@(posedge mclk) disable iff (reset_i)
    !cfg_i.enb |=> !waveform_o);

endmodule

//--- logic/tick_gen.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module tick_gen (
  input  logic                mclk,
  input  logic                reset_i,
  input  pinmux_pkg::us_cnt_t pulse_us_i,
  output logic                ms_tick_o
);

  localparam int unsigned MS_CNT_W = $clog2(`PINMUX_US_PER_MS);
  localparam int unsigned MS_LAST  = `PINMUX_US_PER_MS - 1;

  pinmux_pkg::us_cnt_t us_cnt_q;
  logic                us_tick_q;
  logic [MS_CNT_W-1:0] ms_cnt_q;
  logic                ms_tick_q;

  // ----------------------------------------------------------------------
  // Microsecond divider
  // ----------------------------------------------------------------------
  // Tick every pulse_us_i+1 cycles
  // Compare with >= so a smaller divider takes effect at once
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      us_cnt_q  <= '0;
      us_tick_q <= 1'b0;
    end else if (us_cnt_q >= pulse_us_i) begin
      us_cnt_q  <= '0;
      us_tick_q <= 1'b1;
    end else begin
      us_cnt_q  <= us_cnt_q + 1'b1;
      us_tick_q <= 1'b0;
    end
  end

  // ----------------------------------------------------------------------
  // Millisecond counter
  // ----------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      ms_cnt_q  <= '0;
      ms_tick_q <= 1'b0;
    end else begin
      ms_tick_q <= 1'b0;
      if (us_tick_q) begin
        if (ms_cnt_q == MS_CNT_W'(MS_LAST)) begin
          // Last us tick of the ms, pulse next cycle
          ms_cnt_q  <= '0;
          ms_tick_q <= 1'b1;
        end else begin
          ms_cnt_q <= ms_cnt_q + 1'b1;
        end
      end
    end
  end

  assign ms_tick_o = ms_tick_q;

  // PWM channels count each tick once
  a_ms_tick_single: assert property (@(posedge mclk) disable iff (reset_i)
    ms_tick_o |=> !ms_tick_o);

endmodule

//--- logic/pinmux_regs.sv
`timescale 1ns/100ps
`include "pinmux_config.svh"

module pinmux_regs (
  input  logic                  mclk,
  input  logic                  reset_i,
  input  pinmux_pkg::reg_req_t  reg_req_i,
  output pinmux_pkg::reg_data_t reg_rdata_o,
  output logic                  reg_ack_o,
  input  pinmux_pkg::pad_vec_t  pad_in_i,
  output pinmux_pkg::gpio_cfg_t gpio_cfg_o,
  output pinmux_pkg::pwm_cfg_t  pwm_cfg_o [`PINMUX_PWM_COUNT],
  output pinmux_pkg::us_cnt_t   pulse_us_o
);

  logic                         ack_q;
  pinmux_pkg::reg_data_t        rdata_q;
  pinmux_pkg::gpio_cfg_t        gpio_cfg_q;
  pinmux_pkg::pad_vec_t         gpio_in_q;
  logic [`PINMUX_PWM_COUNT-1:0] pwm_enb_q;
  pinmux_pkg::us_cnt_t          pulse_us_q;
  pinmux_pkg::pwm_time_t        pwm_high_q [`PINMUX_PWM_COUNT];
  pinmux_pkg::pwm_time_t        pwm_low_q [`PINMUX_PWM_COUNT];

  // Current value of the addressed register, byte mask, merged write data
  pinmux_pkg::reg_data_t        cur_val;
  pinmux_pkg::reg_data_t        be_mask;
  pinmux_pkg::reg_data_t        wr_val;
  logic                         access;
  logic                         wr_en;

  // ----------------------------------------------------------------------
  // Bus decode
  // ----------------------------------------------------------------------
  // New access only when ack is not already up
  assign access = reg_req_i.cs & ~ack_q;
  assign wr_en  = access & reg_req_i.wr;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      be_mask[8*b +: 8] = {8{reg_req_i.be[b]}};
    end
    // Untouched bytes keep the stored value
    wr_val = (reg_req_i.wdata & be_mask) | (cur_val & ~be_mask);
  end

  // Read mux, zero for holes in the map
  always_comb begin
    cur_val = '0;
    case (reg_req_i.addr)
      `PINMUX_REG_GPIO_DIR:   cur_val = pinmux_pkg::reg_data_t'(gpio_cfg_q.dir);
      `PINMUX_REG_GPIO_OUT:   cur_val = pinmux_pkg::reg_data_t'(gpio_cfg_q.out);
      `PINMUX_REG_GPIO_IN:    cur_val = pinmux_pkg::reg_data_t'(gpio_in_q);
      `PINMUX_REG_MULTI_FUNC: cur_val = pinmux_pkg::reg_data_t'(pwm_enb_q);
      `PINMUX_REG_PULSE_US:   cur_val = pinmux_pkg::reg_data_t'(pulse_us_q);
      default: ;
    endcase
    // PWM block, high in the low half
    for (int i = 0; i < `PINMUX_PWM_COUNT; i++) begin
      if (reg_req_i.addr ==
          pinmux_pkg::reg_addr_t'(`PINMUX_REG_PWM_BASE + `PINMUX_REG_PWM_STRIDE * i)) begin
        cur_val[`PINMUX_PWM_WIDTH-1:0]                    = pwm_high_q[i];
        cur_val[`PINMUX_PWM_LOW_LSB +: `PINMUX_PWM_WIDTH] = pwm_low_q[i];
      end
    end
  end

  // ----------------------------------------------------------------------
  // Config registers
  // ----------------------------------------------------------------------
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      gpio_cfg_q <= '0;
      pwm_enb_q  <= '0;
      pulse_us_q <= '0;
      for (int i = 0; i < `PINMUX_PWM_COUNT; i++) begin
        pwm_high_q[i] <= '0;
        pwm_low_q[i]  <= '0;
      end
    end else if (wr_en) begin
      // GPIO_IN is read only so writes fall through
      case (reg_req_i.addr)
        `PINMUX_REG_GPIO_DIR:   gpio_cfg_q.dir <= wr_val[`PINMUX_PAD_COUNT-1:0];
        `PINMUX_REG_GPIO_OUT:   gpio_cfg_q.out <= wr_val[`PINMUX_PAD_COUNT-1:0];
        `PINMUX_REG_MULTI_FUNC: pwm_enb_q      <= wr_val[`PINMUX_PWM_COUNT-1:0];
        `PINMUX_REG_PULSE_US:   pulse_us_q     <= wr_val[`PINMUX_US_WIDTH-1:0];
        default: ;
      endcase
      for (int i = 0; i < `PINMUX_PWM_COUNT; i++) begin
        if (reg_req_i.addr ==
            pinmux_pkg::reg_addr_t'(`PINMUX_REG_PWM_BASE + `PINMUX_REG_PWM_STRIDE * i)) begin
          pwm_high_q[i] <= wr_val[`PINMUX_PWM_WIDTH-1:0];
          pwm_low_q[i]  <= wr_val[`PINMUX_PWM_LOW_LSB +: `PINMUX_PWM_WIDTH];
        end
      end
    end
  end

  // Single cycle ack, read data only while ack is up
  always_ff @(posedge mclk) begin
    if (reset_i) begin
      ack_q   <= 1'b0;
      rdata_q <= '0;
    end else begin
      ack_q   <= access;
      rdata_q <= (access & ~reg_req_i.wr) ? cur_val : '0;
    end
  end

  // Pad input snapshot every cycle
  always_ff @(posedge mclk) begin
    gpio_in_q <= pad_in_i;
  end

  // ----------------------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------------------
  assign reg_ack_o   = ack_q;
  assign reg_rdata_o = rdata_q;
  assign gpio_cfg_o  = gpio_cfg_q;
  assign pulse_us_o  = pulse_us_q;

  always_comb begin
    for (int i = 0; i < `PINMUX_PWM_COUNT; i++) begin
      pwm_cfg_o[i].enb  = pwm_enb_q[i];
      pwm_cfg_o[i].high = pwm_high_q[i];
      pwm_cfg_o[i].low  = pwm_low_q[i];
    end
  end

  // Master holds cs through ack, so a second ack would be a double access
  a_ack_single: assert property (@(posedge mclk) disable iff (reset_i)
    reg_ack_o |=> !reg_ack_o);

endmodule

//--- logic/pinmux_pkg.sv
package pinmux_pkg;

  // ----------------------------------------------------------------------
  // Plain vector types
  // ----------------------------------------------------------------------
  // One bit per pad
  typedef logic [15:0] pad_vec_t;
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;
  typedef logic [3:0]  reg_be_t;
  // Microsecond divider value
  typedef logic [9:0]  us_cnt_t;
  // PWM phase length in ms ticks
  typedef logic [15:0] pwm_time_t;

  // ----------------------------------------------------------------------
  // Grouped signals
  // ----------------------------------------------------------------------
  // Register bus request, held by the master until ack
  typedef struct packed {
    logic      cs;
    logic      wr;
    reg_addr_t addr;
    reg_data_t wdata;
    reg_be_t   be;
  } reg_req_t;

  // Per channel PWM setup
  typedef struct packed {
    logic      enb;
    pwm_time_t high;
    pwm_time_t low;
  } pwm_cfg_t;

  // GPIO direction (1 = output) and output data
  typedef struct packed {
    pad_vec_t dir;
    pad_vec_t out;
  } gpio_cfg_t;

  // PWM channel FSM
  typedef enum logic [1:0] {
    PWM_IDLE,
    PWM_HIGH,
    PWM_LOW
  } pwm_phase_e;

endpackage

//--- logic/pinmux_config.svh
`ifndef PINMUX_CONFIG_SVH
`define PINMUX_CONFIG_SVH

// ----------------------------------------------------------------------
// Pad and channel counts
// ----------------------------------------------------------------------
`define PINMUX_PAD_COUNT        16
`define PINMUX_PWM_COUNT        6

// Field widths
`define PINMUX_US_WIDTH         10
`define PINMUX_PWM_WIDTH        16
// Low phase sits in the upper half of a PWM register
`define PINMUX_PWM_LOW_LSB      16

// Microsecond ticks per millisecond tick
`define PINMUX_US_PER_MS        1000

// ----------------------------------------------------------------------
// Register map, byte offsets
// ----------------------------------------------------------------------
`define PINMUX_REG_GPIO_DIR     8'h00
`define PINMUX_REG_GPIO_OUT     8'h04
// Read only
`define PINMUX_REG_GPIO_IN      8'h08
`define PINMUX_REG_MULTI_FUNC   8'h0C
`define PINMUX_REG_PULSE_US     8'h10
`define PINMUX_REG_PWM_BASE     8'h20
`define PINMUX_REG_PWM_STRIDE   4

`endif
